/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/id_pkg.sv
      - hw/id_decoder.sv
      - hw/id_reg_file.sv
      - hw/id_imm_gen.sv
      - hw/id_branch_resolve.sv
      - hw/id_stage.sv
  - target: test
    files:
      - verification/id_stage_asserts.sv
      - verification/id_stage_tb.sv

/* hw/id_branch_resolve.sv */
`timescale 1ns/1ns

module id_branch_resolve (
    input  logic                 is_branch,
    input  id_pkg::branch_type_e branch_type,
    input  id_pkg::word_t        pc,
    input  id_pkg::word_t        imm,
    input  id_pkg::reg_addr_t    rs1,
    input  id_pkg::reg_addr_t    rs2,
    input  id_pkg::word_t        rs1_data,
    input  id_pkg::word_t        rs2_data,
    input  logic                 pred_valid,
    input  id_pkg::word_t        pred_pc,
    input  logic                 mem_fwd_valid,
    input  logic                 mem_fwd_reg_write,
    input  id_pkg::reg_addr_t    mem_fwd_rd,
    input  id_pkg::word_t        mem_fwd_result,
    output logic                 redirect,
    output id_pkg::word_t        redirect_target
);
    import id_pkg::*;

    logic  fwd_ok;
    logic  fwd_rs1;
    logic  fwd_rs2;
    word_t op1;
    word_t op2;
    logic  taken;
    word_t taken_target;
    word_t fall_target;

    // ------------------------------
    // MEM to ID forwarding
    // ------------------------------

    // WB results already arrive through the register file bypass
    assign fwd_ok  = mem_fwd_valid && mem_fwd_reg_write && (mem_fwd_rd != '0);
    assign fwd_rs1 = fwd_ok && (mem_fwd_rd == rs1);
    assign fwd_rs2 = fwd_ok && (mem_fwd_rd == rs2);

    assign op1 = fwd_rs1 ? mem_fwd_result : rs1_data;
    assign op2 = fwd_rs2 ? mem_fwd_result : rs2_data;

    // ------------------------------
    // Condition and targets
    // ------------------------------

    always_comb begin
        case (branch_type)
            BR_EQ:   taken = (op1 == op2);
            BR_NE:   taken = (op1 != op2);
            BR_LT:   taken = ($signed(op1) < $signed(op2));
            BR_GE:   taken = ($signed(op1) >= $signed(op2));
            BR_LTU:  taken = (op1 < op2);
            BR_GEU:  taken = (op1 >= op2);
            default: taken = 1'b0;
        endcase
    end

    assign taken_target = pc + imm;
    assign fall_target  = pc + word_t'(4);

    // Mispredict check against the fetch prediction
    always_comb begin
        redirect        = 1'b0;
        redirect_target = '0;
        if (is_branch) begin
            if (taken) begin
                if (!pred_valid || pred_pc != taken_target) begin
                    redirect        = 1'b1; // Missed or wrong target
                    redirect_target = taken_target;
                end
            end else if (pred_valid) begin
                redirect        = 1'b1; // Predicted but falls through
                redirect_target = fall_target;
            end
        end
    end

endmodule

/* hw/id_decoder.sv */
`timescale 1ns/1ns

module id_decoder (
    input  logic                     in_valid,
    input  logic                     flush,
    input  id_pkg::insn_t            insn,
    output logic                     out_valid,
    output logic                     src1_pc,
    output logic                     src2_imm,
    output logic                     reg_write,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     mem_unsigned,
    output logic                     is_branch,
    output logic                     is_jump,
    output logic                     illegal,
    output id_pkg::alu_op_e          alu_op,
    output id_pkg::branch_type_e     branch_type,
    output id_pkg::mem_width_e       mem_width,
    output id_pkg::imm_sel_e         imm_sel,
    output id_pkg::reg_addr_t        rd,
    output id_pkg::reg_addr_t        rs1,
    output id_pkg::reg_addr_t        rs2
);
    import id_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = opcode_e'(insn[6:0]);
    assign funct3   = insn[14:12];
    assign funct7_5 = insn[30]; // SUB / SRA / SRAI select

    // Access size from the low funct3 bits
    function automatic mem_width_e width_of(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return MEM_BYTE;
            2'b01:   return MEM_HALF;
            default: return MEM_WORD;
        endcase
    endfunction

    // ------------------------------
    // Control decode
    // ------------------------------

    always_comb begin
        out_valid    = 1'b0;
        src1_pc      = 1'b0;
        src2_imm     = 1'b0;
        reg_write    = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_unsigned = 1'b0;
        is_branch    = 1'b0;
        is_jump      = 1'b0;
        illegal      = 1'b0;
        alu_op       = ALU_ADD;
        branch_type  = BR_NONE;
        mem_width    = MEM_BYTE;
        imm_sel      = IMM_NONE;
        rd           = '0;
        rs1          = '0;
        rs2          = '0;

        if (in_valid && !flush) begin
            out_valid = 1'b1;
            rd        = insn[11:7];
            rs1       = insn[19:15];
            rs2       = insn[24:20];

            case (opcode)
                OP_LUI: begin
                    alu_op    = ALU_LUI;
                    src2_imm  = 1'b1;
                    reg_write = 1'b1;
                    imm_sel   = IMM_U;
                end
                OP_AUIPC: begin
                    alu_op    = ALU_AUIPC;
                    src1_pc   = 1'b1;
                    src2_imm  = 1'b1;
                    reg_write = 1'b1;
                    imm_sel   = IMM_U;
                end
                OP_JAL: begin
                    src1_pc   = 1'b1;
                    src2_imm  = 1'b1;
                    is_jump   = 1'b1;
                    reg_write = 1'b1;
                    imm_sel   = IMM_J;
                end
                OP_JALR: begin
                    src2_imm  = 1'b1; // rs1 + imm
                    is_jump   = 1'b1;
                    reg_write = 1'b1;
                    imm_sel   = IMM_I;
                end
                OP_BRANCH: begin
                    src1_pc   = 1'b1;
                    src2_imm  = 1'b1;
                    is_branch = 1'b1;
                    imm_sel   = IMM_B;
                    case (funct3)
                        3'b000:  branch_type = BR_EQ;
                        3'b001:  branch_type = BR_NE;
                        3'b100:  branch_type = BR_LT;
                        3'b101:  branch_type = BR_GE;
                        3'b110:  branch_type = BR_LTU;
                        3'b111:  branch_type = BR_GEU;
                        default: branch_type = BR_NONE; // Never taken
                    endcase
                end
                OP_LOAD: begin
                    src2_imm     = 1'b1;
                    mem_read     = 1'b1;
                    reg_write    = 1'b1;
                    imm_sel      = IMM_I;
                    mem_width    = width_of(funct3);
                    mem_unsigned = funct3[2]; // LBU / LHU
                end
                OP_STORE: begin
                    src2_imm     = 1'b1;
                    mem_write    = 1'b1;
                    imm_sel      = IMM_S;
                    mem_width    = width_of(funct3);
                    mem_unsigned = funct3[2];
                end
                OP_IMM: begin
                    src2_imm  = 1'b1;
                    reg_write = 1'b1;
                    imm_sel   = IMM_I;
                    case (funct3)
                        3'b001:  alu_op = ALU_SLL;
                        3'b010:  alu_op = ALU_SLT;
                        3'b011:  alu_op = ALU_SLTU;
                        3'b100:  alu_op = ALU_XOR;
                        3'b101:  alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: alu_op = ALU_ADD; // ADDI
                    endcase
                end
                OP_REG: begin
                    reg_write = 1'b1;
                    case (funct3)
                        3'b001:  alu_op = ALU_SLL;
                        3'b010:  alu_op = ALU_SLT;
                        3'b011:  alu_op = ALU_SLTU;
                        3'b100:  alu_op = ALU_XOR;
                        3'b101:  alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
                        3'b110:  alu_op = ALU_OR;
                        3'b111:  alu_op = ALU_AND;
                        default: alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
                    endcase
                end
                default: begin
                    // Unknown, CSR, SYSTEM and FENCE opcodes
                    illegal = 1'b1;
                end
            endcase
        end
    end

endmodule

/* hw/id_imm_gen.sv */
`timescale 1ns/1ns
`include "id_config.svh"

module id_imm_gen (
    input  id_pkg::insn_t    insn,
    input  id_pkg::imm_sel_e imm_sel,
    output id_pkg::word_t    imm
);
    import id_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Sign bit is always insn[31]
    assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{(`XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                    insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0}; // Upper 20 bits
    assign imm_j = {{(`XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
                    insn[30:21], 1'b0};

    // ------------------------------
    // Format select
    // ------------------------------

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = imm_i;
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = '0;
        endcase
    end

endmodule

/* hw/id_pkg.sv */
`include "id_config.svh"

package id_pkg;

    // ------------------------------
    // Plain vector types
    // ------------------------------

    typedef logic [`XLEN-1:0]       word_t;     // Data, PC, immediates
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`INSN_W-1:0]     insn_t;

    // ------------------------------
    // Encodings
    // ------------------------------

    // RV32I major opcodes handled by decode
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,   // Pass immediate
        ALU_AUIPC  // PC plus immediate
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_type_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_width_e;

    // Immediate formats where NONE yields zero
    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

endpackage

/* hw/id_reg_file.sv */
`timescale 1ns/1ns
`include "id_config.svh"

module id_reg_file (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::reg_addr_t rs1,
    input  id_pkg::reg_addr_t rs2,
    input  logic              wb_en,
    input  id_pkg::reg_addr_t wb_rd,
    input  id_pkg::word_t     wb_data,
    output id_pkg::word_t     rs1_data,
    output id_pkg::word_t     rs2_data
);
    import id_pkg::*;

    word_t regs [`REG_COUNT];

    // ------------------------------
    // Write port
    // ------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin // x0 stays zero
            regs[wb_rd] <= wb_data;
        end
    end

    // ------------------------------
    // Read ports with WB bypass
    // ------------------------------

    always_comb begin
        if (rs1 == '0)
            rs1_data = '0;
        else if (wb_en && wb_rd == rs1)
            rs1_data = wb_data; // Same-cycle write
        else
            rs1_data = regs[rs1];

        if (rs2 == '0)
            rs2_data = '0;
        else if (wb_en && wb_rd == rs2)
            rs2_data = wb_data;
        else
            rs2_data = regs[rs2];
    end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ns

module id_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 flush,
    input  id_pkg::word_t        pc,
    input  id_pkg::insn_t        insn,
    input  logic                 pred_valid,
    input  id_pkg::word_t        pred_pc,
    input  logic                 wb_en,
    input  id_pkg::reg_addr_t    wb_rd,
    input  id_pkg::word_t        wb_data,
    input  logic                 mem_fwd_valid,
    input  logic                 mem_fwd_reg_write,
    input  id_pkg::reg_addr_t    mem_fwd_rd,
    input  id_pkg::word_t        mem_fwd_result,
    output logic                 out_valid,
    output id_pkg::alu_op_e      alu_op,
    output logic                 src1_pc,
    output logic                 src2_imm,
    output logic                 reg_write,
    output logic                 mem_read,
    output logic                 mem_write,
    output id_pkg::mem_width_e   mem_width,
    output logic                 mem_unsigned,
    output logic                 is_branch,
    output logic                 is_jump,
    output id_pkg::branch_type_e branch_type,
    output logic                 illegal,
    output id_pkg::reg_addr_t    rd,
    output id_pkg::reg_addr_t    rs1,
    output id_pkg::reg_addr_t    rs2,
    output id_pkg::word_t        rs1_data,
    output id_pkg::word_t        rs2_data,
    output id_pkg::word_t        imm,
    output id_pkg::word_t        out_pc,
    output logic                 pred_valid_out,
    output id_pkg::word_t        pred_pc_out,
    output logic                 redirect,
    output id_pkg::word_t        redirect_target
);
    import id_pkg::*;

    imm_sel_e imm_sel;

    id_decoder u_decoder (
        .in_valid, .flush, .insn, .out_valid, .src1_pc, .src2_imm, .reg_write,
        .mem_read, .mem_write, .mem_unsigned, .is_branch, .is_jump, .illegal,
        .alu_op, .branch_type, .mem_width, .imm_sel, .rd, .rs1, .rs2
    );

    id_reg_file u_reg_file (
        .clk, .rst, .rs1, .rs2, .wb_en, .wb_rd, .wb_data, .rs1_data, .rs2_data
    );

    id_imm_gen u_imm_gen (.insn, .imm_sel, .imm);

    // Uses the gated branch flag so a flushed branch never redirects
    id_branch_resolve u_branch_resolve (
        .is_branch, .branch_type, .pc, .imm, .rs1, .rs2, .rs1_data, .rs2_data,
        .pred_valid, .pred_pc, .mem_fwd_valid, .mem_fwd_reg_write, .mem_fwd_rd,
        .mem_fwd_result, .redirect, .redirect_target
    );

    // PC and prediction pass through only with a live instruction
    assign out_pc         = out_valid ? pc : '0;
    assign pred_valid_out = out_valid && pred_valid;
    assign pred_pc_out    = out_valid ? pred_pc : '0;

endmodule

/* include/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Data, address and immediate width
`define XLEN 32

// Raw instruction word
`define INSN_W 32

// ------------------------------
// Register file geometry
// ------------------------------

`define REG_COUNT 32 // Architectural registers x0..x31

`define REG_ADDR_W 5 // log2 of REG_COUNT

`endif

/* verification/id_stage_asserts.sv */
`timescale 1ns/1ns

module id_stage_asserts (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              out_valid,
    input logic              is_branch,
    input logic              redirect,
    input id_pkg::reg_addr_t rs1,
    input id_pkg::word_t     rs1_data
);

    int unsigned failures = 0; // Count of failed checks

    // ------------------------------
    // Stage invariants
    // ------------------------------

    // Only a decoded conditional branch may steer fetch
    redirect_needs_branch: assert property (
        @(posedge clk) disable iff (rst) redirect |-> is_branch
    ) else begin
        failures++;
        $error("redirect raised without a decoded branch");
    end

    flush_kills_valid: assert property (
        @(posedge clk) disable iff (rst) flush |-> !out_valid
    ) else begin
        failures++;
        $error("out_valid high while flush is asserted");
    end

    // Forwarding only feeds the resolver so x0 always reads zero
    x0_reads_zero: assert property (
        @(posedge clk) disable iff (rst) (rs1 == '0) |-> (rs1_data == '0)
    ) else begin
        failures++;
        $error("rs1_data is nonzero for register x0");
    end

endmodule

bind id_stage id_stage_asserts u_asserts (.*);

/* verification/id_stage_tb.sv */
`timescale 1ns/1ns

module id_stage_tb;
    import id_pkg::*;

    // One table row with stimulus first and expected outputs after
    typedef struct {
        string      name;
        logic       in_valid;
        logic       flush;
        word_t      pc;
        insn_t      insn;
        logic       pred_valid;
        word_t      pred_pc;
        logic       wb_en;
        reg_addr_t  wb_rd;
        word_t      wb_data;
        logic       mf_valid;
        logic       mf_reg_write;
        reg_addr_t  mf_rd;
        word_t      mf_result;
        logic       exp_out_valid;
        alu_op_e    exp_alu_op;
        logic       exp_reg_write;
        logic       exp_mem_read;
        logic       exp_mem_write;
        mem_width_e exp_mem_width;
        logic       exp_mem_unsigned;
        logic       exp_illegal;
        word_t      exp_imm;
        logic       exp_redirect;
        word_t      exp_target;
        logic [3:0] exp_ctl;    // src1_pc, src2_imm, is_branch, is_jump
        branch_type_e exp_branch;
    } row_t;

    logic         clk, rst, in_valid, flush, pred_valid, wb_en;
    logic         mem_fwd_valid, mem_fwd_reg_write;
    word_t        pc, pred_pc, wb_data, mem_fwd_result;
    insn_t        insn;
    reg_addr_t    wb_rd, mem_fwd_rd;
    logic         out_valid, src1_pc, src2_imm, reg_write, mem_read, mem_write;
    logic         mem_unsigned, is_branch, is_jump, illegal, pred_valid_out, redirect;
    alu_op_e      alu_op;
    branch_type_e branch_type;
    mem_width_e   mem_width;
    reg_addr_t    rd, rs1, rs2;
    word_t        rs1_data, rs2_data, imm, out_pc, pred_pc_out, redirect_target;

    row_t  rows[$];
    word_t model_regs [32];

    id_stage id_stage_i (.*);

    // ------------------------------
    // Instruction encoders
    // ------------------------------

    function automatic insn_t r_insn(logic [6:0] f7, reg_addr_t rs2_i, reg_addr_t rs1_i,
                                     logic [2:0] f3, reg_addr_t rd_i);
        return {f7, rs2_i, rs1_i, f3, rd_i, OP_REG};
    endfunction

    function automatic insn_t i_insn(logic [11:0] im, reg_addr_t rs1_i, logic [2:0] f3,
                                     reg_addr_t rd_i, opcode_e op);
        return {im, rs1_i, f3, rd_i, op};
    endfunction

    function automatic insn_t s_insn(logic [11:0] im, reg_addr_t rs2_i, reg_addr_t rs1_i,
                                     logic [2:0] f3);
        return {im[11:5], rs2_i, rs1_i, f3, im[4:0], OP_STORE};
    endfunction

    function automatic insn_t b_insn(logic [12:0] im, reg_addr_t rs2_i, reg_addr_t rs1_i,
                                     logic [2:0] f3);
        return {im[12], im[10:5], rs2_i, rs1_i, f3, im[4:1], im[11], OP_BRANCH};
    endfunction

    function automatic insn_t u_insn(logic [19:0] im, reg_addr_t rd_i, opcode_e op);
        return {im, rd_i, op};
    endfunction

    function automatic insn_t j_insn(logic [20:0] im, reg_addr_t rd_i);
        return {im[20], im[10:1], im[11], im[19:12], rd_i, OP_JAL};
    endfunction

    // Register model with write-back bypass and decode gating
    function automatic word_t read_model(row_t r, reg_addr_t idx);
        if (!r.in_valid || r.flush || idx == '0)
            return '0;
        if (r.wb_en && r.wb_rd == idx)
            return r.wb_data;
        return model_regs[idx];
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_field(string test, string field, logic [31:0] expected,
                               logic [31:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("mismatch %s %s: expected 0x%08h actual 0x%08h",
                                test, field, expected, actual));
    endtask

    // Bound checker failures end the run as well
    always @(id_stage_i.u_asserts.failures) begin
        if (id_stage_i.u_asserts.failures != 0)
            fail_run("a bound assertion on id_stage failed");
    end

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic build_table();
        // x1..x5 are loaded by the first rows
        rows.push_back(row_t'{"r_add_reset", '1, '0, 32'h100,
            r_insn(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_sub_bypass", '1, '0, 32'h104,
            r_insn(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), '0, '0, '1, 5'd1, 32'h11, '0, '0, '0, '0,
            '1, ALU_SUB, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_sll_bypass", '1, '0, 32'h108,
            r_insn(7'h00, 5'd2, 5'd1, 3'b001, 5'd5), '0, '0, '1, 5'd2, 32'hffff_fff0,
            '0, '0, '0, '0, '1, ALU_SLL, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0,
            4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_sltu_x0_write", '1, '0, 32'h10c,
            r_insn(7'h00, 5'd1, 5'd0, 3'b011, 5'd6), '0, '0, '1, 5'd0, 32'hdead_beef,
            '0, '0, '0, '0, '1, ALU_SLTU, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0,
            4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_xor", '1, '0, 32'h110,
            r_insn(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), '0, '0, '1, 5'd3, 32'h100, '0, '0, '0, '0,
            '1, ALU_XOR, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_sra", '1, '0, 32'h114,
            r_insn(7'h20, 5'd2, 5'd1, 3'b101, 5'd8), '0, '0, '1, 5'd4, 32'h8000_0000,
            '0, '0, '0, '0, '1, ALU_SRA, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0,
            4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_or", '1, '0, 32'h118,
            r_insn(7'h00, 5'd4, 5'd3, 3'b110, 5'd9), '0, '0, '1, 5'd5, 32'h11, '0, '0, '0, '0,
            '1, ALU_OR, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"i_slti", '1, '0, 32'h11c,
            i_insn(12'h7ff, 5'd2, 3'b010, 5'd10, OP_IMM), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_SLT, '1, '0, '0, MEM_BYTE, '0, '0, 32'h7ff, '0, '0, 4'b0100, BR_NONE});
        rows.push_back(row_t'{"i_srli", '1, '0, 32'h120,
            i_insn(12'h004, 5'd4, 3'b101, 5'd11, OP_IMM), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_SRL, '1, '0, '0, MEM_BYTE, '0, '0, 32'h4, '0, '0, 4'b0100, BR_NONE});
        rows.push_back(row_t'{"i_srai", '1, '0, 32'h124,
            i_insn(12'h404, 5'd4, 3'b101, 5'd12, OP_IMM), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_SRA, '1, '0, '0, MEM_BYTE, '0, '0, 32'h404, '0, '0, 4'b0100, BR_NONE});
        rows.push_back(row_t'{"i_andi", '1, '0, 32'h128,
            i_insn(12'h800, 5'd3, 3'b111, 5'd13, OP_IMM), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_AND, '1, '0, '0, MEM_BYTE, '0, '0, 32'hffff_f800, '0, '0,
            4'b0100, BR_NONE});
        rows.push_back(row_t'{"lui", '1, '0, 32'h12c,
            u_insn(20'habcde, 5'd14, OP_LUI), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_LUI, '1, '0, '0, MEM_BYTE, '0, '0, 32'habcd_e000, '0, '0,
            4'b0100, BR_NONE});
        rows.push_back(row_t'{"auipc", '1, '0, 32'h130,
            u_insn(20'h00001, 5'd15, OP_AUIPC), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_AUIPC, '1, '0, '0, MEM_BYTE, '0, '0, 32'h1000, '0, '0, 4'b1100, BR_NONE});
        rows.push_back(row_t'{"jal_back", '1, '0, 32'h134,
            j_insn(21'h1ffff0, 5'd1), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '0, '0, MEM_BYTE, '0, '0, 32'hffff_fff0, '0, '0,
            4'b1101, BR_NONE});
        rows.push_back(row_t'{"jalr", '1, '0, 32'h138,
            i_insn(12'h010, 5'd3, 3'b000, 5'd1, OP_JALR), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '0, '0, MEM_BYTE, '0, '0, 32'h10, '0, '0, 4'b0101, BR_NONE});
        rows.push_back(row_t'{"lh", '1, '0, 32'h13c,
            i_insn(12'hffc, 5'd3, 3'b001, 5'd16, OP_LOAD), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '1, '0, MEM_HALF, '0, '0, 32'hffff_fffc, '0, '0,
            4'b0100, BR_NONE});
        rows.push_back(row_t'{"lbu", '1, '0, 32'h140,
            i_insn(12'h003, 5'd3, 3'b100, 5'd17, OP_LOAD), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '1, '0, MEM_BYTE, '1, '0, 32'h3, '0, '0, 4'b0100, BR_NONE});
        rows.push_back(row_t'{"sw", '1, '0, 32'h144,
            s_insn(12'h024, 5'd2, 5'd3, 3'b010), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '1, MEM_WORD, '0, '0, 32'h24, '0, '0, 4'b0100, BR_NONE});
        rows.push_back(row_t'{"illegal_ecall", '1, '0, 32'h148,
            32'h0000_0073, '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '1, '0, '0, '0, 4'b0000, BR_NONE});
        // Branches with x1=0x11, x2=-16, x4=0x80000000, x5=0x11
        rows.push_back(row_t'{"beq_taken_nopred", '1, '0, 32'h200,
            b_insn(13'h010, 5'd5, 5'd1, 3'b000), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h10, '1, 32'h210, 4'b1110, BR_EQ});
        rows.push_back(row_t'{"bne_taken_wrong_pred", '1, '0, 32'h204,
            b_insn(13'h1ff8, 5'd2, 5'd1, 3'b001), '1, 32'h208, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'hffff_fff8, '1, 32'h1fc,
            4'b1110, BR_NE});
        rows.push_back(row_t'{"blt_not_taken_pred", '1, '0, 32'h208,
            b_insn(13'h020, 5'd2, 5'd1, 3'b100), '1, 32'h228, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h20, '1, 32'h20c, 4'b1110, BR_LT});
        rows.push_back(row_t'{"bge_taken_pred_ok", '1, '0, 32'h20c,
            b_insn(13'h040, 5'd2, 5'd1, 3'b101), '1, 32'h24c, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h40, '0, '0, 4'b1110, BR_GE});
        rows.push_back(row_t'{"bltu_not_taken_nopred", '1, '0, 32'h210,
            b_insn(13'h008, 5'd1, 5'd2, 3'b110), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h8, '0, '0, 4'b1110, BR_LTU});
        rows.push_back(row_t'{"bgeu_taken_nopred", '1, '0, 32'h214,
            b_insn(13'h1000, 5'd1, 5'd4, 3'b111), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'hffff_f000, '1, 32'hffff_f214,
            4'b1110, BR_GEU});
        // MEM result 0x22 for x1 turns an equal pair into a taken bne
        rows.push_back(row_t'{"fwd_rs1_bne", '1, '0, 32'h218,
            b_insn(13'h010, 5'd5, 5'd1, 3'b001), '0, '0, '0, '0, '0, '1, '1, 5'd1, 32'h22,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h10, '1, 32'h228, 4'b1110, BR_NE});
        rows.push_back(row_t'{"fwd_rd0_ignored", '1, '0, 32'h21c,
            b_insn(13'h010, 5'd5, 5'd0, 3'b000), '0, '0, '0, '0, '0, '1, '1, 5'd0, 32'h11,
            '1, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, 32'h10, '0, '0, 4'b1110, BR_EQ});
        rows.push_back(row_t'{"flush_branch", '1, '1, 32'h220,
            b_insn(13'h010, 5'd5, 5'd1, 3'b000), '1, 32'h300, '0, '0, '0, '0, '0, '0, '0,
            '0, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"idle_write_x6", '0, '0, 32'h224,
            u_insn(20'h12345, 5'd6, OP_LUI), '0, '0, '1, 5'd6, 32'h66, '0, '0, '0, '0,
            '0, ALU_ADD, '0, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
        rows.push_back(row_t'{"r_add_read_x6", '1, '0, 32'h228,
            r_insn(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), '0, '0, '0, '0, '0, '0, '0, '0, '0,
            '1, ALU_ADD, '1, '0, '0, MEM_BYTE, '0, '0, '0, '0, '0, 4'b0000, BR_NONE});
    endtask

    // ------------------------------
    // Clock and reset
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

    initial begin
        int    waited;
        row_t  r;
        word_t exp_rs1;
        word_t exp_rs2;
        logic  live;

        rst               = 1'b1;
        in_valid          = 1'b0;
        flush             = 1'b0;
        pc                = '0;
        insn              = '0;
        pred_valid        = 1'b0;
        pred_pc           = '0;
        wb_en             = 1'b0;
        wb_rd             = '0;
        wb_data           = '0;
        mem_fwd_valid     = 1'b0;
        mem_fwd_reg_write = 1'b0;
        mem_fwd_rd        = '0;
        mem_fwd_result    = '0;
        foreach (model_regs[i])
            model_regs[i] = '0; // Reset clears every register
        build_table();

        waited = 0;
        while (rst) begin
            @(posedge clk);
            waited++;
            if (waited > 8)
                fail_run("reset still asserted after 8 clock cycles");
        end

        foreach (rows[k]) begin
            r = rows[k];
            @(posedge clk);
            in_valid          <= r.in_valid;
            flush             <= r.flush;
            pc                <= r.pc;
            insn              <= r.insn;
            pred_valid        <= r.pred_valid;
            pred_pc           <= r.pred_pc;
            wb_en             <= r.wb_en;
            wb_rd             <= r.wb_rd;
            wb_data           <= r.wb_data;
            mem_fwd_valid     <= r.mf_valid;
            mem_fwd_reg_write <= r.mf_reg_write;
            mem_fwd_rd        <= r.mf_rd;
            mem_fwd_result    <= r.mf_result;

            @(negedge clk); // Outputs settled by mid cycle
            exp_rs1 = read_model(r, r.insn[19:15]);
            exp_rs2 = read_model(r, r.insn[24:20]);
            live    = r.in_valid && !r.flush;
            check_field(r.name, "out_valid", r.exp_out_valid, out_valid);
            check_field(r.name, "alu_op", r.exp_alu_op, alu_op);
            check_field(r.name, "reg_write", r.exp_reg_write, reg_write);
            check_field(r.name, "mem_read", r.exp_mem_read, mem_read);
            check_field(r.name, "mem_write", r.exp_mem_write, mem_write);
            check_field(r.name, "mem_width", r.exp_mem_width, mem_width);
            check_field(r.name, "mem_unsigned", r.exp_mem_unsigned, mem_unsigned);
            check_field(r.name, "illegal", r.exp_illegal, illegal);
            check_field(r.name, "controls", r.exp_ctl,
                        {src1_pc, src2_imm, is_branch, is_jump});
            check_field(r.name, "branch_type", r.exp_branch, branch_type);
            check_field(r.name, "imm", r.exp_imm, imm);
            check_field(r.name, "rs1_data", exp_rs1, rs1_data);
            check_field(r.name, "rs2_data", exp_rs2, rs2_data);
            check_field(r.name, "redirect", r.exp_redirect, redirect);
            check_field(r.name, "redirect_target", r.exp_target, redirect_target);

            // Fields and prediction only pass with a live instruction
            check_field(r.name, "rd", live ? r.insn[11:7] : 5'd0, rd);
            check_field(r.name, "rs1", live ? r.insn[19:15] : 5'd0, rs1);
            check_field(r.name, "rs2", live ? r.insn[24:20] : 5'd0, rs2);
            check_field(r.name, "out_pc", live ? r.pc : '0, out_pc);
            check_field(r.name, "pred_valid_out", live && r.pred_valid, pred_valid_out);
            check_field(r.name, "pred_pc_out", live ? r.pred_pc : '0, pred_pc_out);

            // Array update lands at the next rising edge
            if (r.wb_en && r.wb_rd != '0)
                model_regs[r.wb_rd] = r.wb_data;
        end

        @(negedge clk); // Last row also seen by the bound checks
        $display("No errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_reg_file.sv
hw/id_imm_gen.sv
hw/id_branch_resolve.sv
hw/id_stage.sv
verification/id_stage_asserts.sv
verification/id_stage_tb.sv
